// File: mult4_stim.txt
// one vector per line as five hex digits
// digit 1 valid, digit 2 a, digit 3 b, digits 4 and 5 expected product
1350f
1762a
19b63
1cd9c
1a532
00000
10700
1e000
1ffe1
11909
18108
11f0f
05500
16418
02300
0ff00
1b74d
1deb6
12810

// File: tb.f
+incdir+.
mult_pkg.sv
pp_if.sv
pp_gen.sv
ks_adder.sv
pp_reduce.sv
mult4_top.sv
mult4_chk.sv
mult4_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= mult4_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SOURCES   := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: mult4_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mult_macros.svh"

module mult4_tb
    import mult_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 2;
    localparam int DRIVE_DLY  = 2;   // ns after the rising edge
    localparam int MAX_STIM   = 32;  // depth of the stim array
    localparam int RAND_N     = 64;
    localparam int TIMEOUT_NS = (RST_CYCLES + MAX_STIM + RAND_N + 40) * CLK_PERIOD;

    typedef struct packed {
        int       due;    // cycle at which the result is checked
        logic     valid;
        product_t prod;
    } expect_t;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    operand_t a;
    operand_t b;
    logic     out_valid;
    product_t product;

    expect_t     exp_q [$];              // results still in flight
    logic [19:0] stim_mem [MAX_STIM];
    int          n_stim;
    int          cyc;
    int          n_checks;
    int          n_errors;
    product_t    last_prod;              // product holds this through bubbles
    integer      seed;

    mult4_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .product   (product)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error: %s is %0h, expected %0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic drive_vector(input logic v, input operand_t va, input operand_t vb,
                                input product_t p);
        expect_t rec;
        @(posedge clk);
        #(DRIVE_DLY);
        in_valid  = v;
        a         = va;
        b         = vb;
        rec.due   = cyc + `MULT_LATENCY;  // two edges to the output registers
        rec.valid = v;
        rec.prod  = p;
        exp_q.push_back(rec);
    endtask

    task automatic end_stream_and_drain();
        @(posedge clk);
        #(DRIVE_DLY);
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        while (exp_q.size() != 0) @(posedge clk);
    endtask

    task automatic report_test(input string name, input int c0, input int e0);
        $display("test %s finished, %0d checks, %0d errors", name, n_checks - c0,
                 n_errors - e0);
    endtask

    // compare outputs mid-cycle, away from the edges
    always @(negedge clk) begin : monitor
        expect_t rec;
        if (rst_n) begin
            if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
                rec = exp_q.pop_front();
                check_value("out_valid", 32'(out_valid), 32'(rec.valid));
                if (rec.valid) begin
                    last_prod = rec.prod;
                end
                check_value("product", 32'(product), 32'(last_prod));
            end else begin
                check_value("out_valid", 32'(out_valid), 32'h0);  // no strobe expected
            end
        end
    end

    initial begin : main
        int          c0;
        int          e0;
        logic [31:0] r;
        operand_t    ra;
        operand_t    rb;
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        a         = '0;
        b         = '0;
        cyc       = 0;
        n_checks  = 0;
        n_errors  = 0;
        last_prod = '0;
        seed      = 32'hfe82_8246;
        for (int i = 0; i < MAX_STIM; i++) begin
            stim_mem[i] = '1;  // valid digit f marks the end
        end
        $readmemh("mult4_stim.txt", stim_mem);
        n_stim = 0;
        while (n_stim < MAX_STIM && stim_mem[n_stim][19:16] != 4'hf) n_stim++;

        repeat (RST_CYCLES) @(posedge clk);
        #(DRIVE_DLY);
        rst_n = 1'b1;
        c0 = n_checks;
        e0 = n_errors;
        @(negedge clk);
        check_value("out_valid", 32'(out_valid), 32'h0);
        check_value("product", 32'(product), 32'h0);
        report_test("reset", c0, e0);

        c0 = n_checks;
        e0 = n_errors;
        if (n_stim == 0) begin
            n_errors++;
            $display("the stim file mult4_stim.txt held no vectors");
        end
        for (int i = 0; i < n_stim; i++) begin
            drive_vector(stim_mem[i][16], stim_mem[i][15:12], stim_mem[i][11:8],
                         stim_mem[i][7:0]);
        end
        end_stream_and_drain();
        report_test("stim_vectors", c0, e0);

        c0 = n_checks;
        e0 = n_errors;
        for (int i = 0; i < RAND_N; i++) begin
            r  = $random(seed);
            ra = r[7:4];
            rb = r[11:8];
            drive_vector(r[0], ra, rb, product_t'(ra) * product_t'(rb));
        end
        end_stream_and_drain();
        report_test("random_stream", c0, e0);

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout, the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: mult4_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "mult_macros.svh"

module mult4_chk
    import mult_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     in_valid,
    input operand_t a,
    input operand_t b,
    input logic     out_valid,
    input product_t product
);

    // strobe leaves exactly MULT_LATENCY edges after it entered
    a_valid_delay: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, `MULT_LATENCY)
    ) else $error("out_valid does not follow in_valid by the pipeline latency");

    // both stages flushed by reset until a new operand crosses them
    a_reset_quiet: assert property (
        @(posedge clk) $past(!rst_n, `MULT_LATENCY) |-> !out_valid
    ) else $error("out_valid high within the pipeline latency after reset");

    // product of the operands that entered with the strobe
    a_product: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> product == product_t'($past(a, `MULT_LATENCY))
                                 * product_t'($past(b, `MULT_LATENCY))
    ) else $error("product differs from the delayed operands multiplied");

endmodule

bind mult4_top mult4_chk i_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .product   (product)
);

`default_nettype wire

// File: mult4_top.sv
`timescale 1ns/1ps
`default_nettype none

module mult4_top
    import mult_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,   // one-cycle operand strobe
    input  operand_t a,
    input  operand_t b,
    output logic     out_valid,  // two edges after in_valid
    output product_t product
);

    // rows between the two pipeline stages
    pp_if i_pp (
        .clk (clk)
    );

    // stage 1, operand registers and AND array
    pp_gen i_pp_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .pp       (i_pp.gen)
    );

    // stage 2, reduction, final add and output registers
    pp_reduce i_pp_reduce (
        .clk       (clk),
        .rst_n     (rst_n),
        .pp        (i_pp.red),
        .out_valid (out_valid),
        .product   (product)
    );

endmodule

`default_nettype wire

// File: pp_reduce.sv
`timescale 1ns/1ps
`default_nettype none

`include "mult_macros.svh"

module pp_reduce
    import mult_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    pp_if.red        pp,
    output logic     out_valid,
    output product_t product
);

    localparam int ADD_W = `MULT_PROD_W - 2;  // final add covers columns 1 to 6

    pp_row_t pp0;
    pp_row_t pp1;
    pp_row_t pp2;
    pp_row_t pp3;

    logic [2:0]       red_a;      // 3-bit compressor, columns 2 to 4
    logic [2:0]       red_b;
    logic [2:0]       red_s;
    logic             red_c;      // lands in column 5
    logic             ha_s;       // half adder, column 3
    logic             ha_c;       // lands in column 4
    logic [1:0]       hi_a;       // 2-bit adder, columns 4 and 5
    logic [1:0]       hi_b;
    logic [1:0]       hi_s;
    logic             hi_c;       // lands in column 6
    logic [ADD_W-1:0] add_x;      // final addends, bit 0 is column 1
    logic [ADD_W-1:0] add_y;
    logic [ADD_W-1:0] add_s;
    logic             add_c;      // product msb
    product_t         product_d;

    assign pp0 = pp.rows[0];
    assign pp1 = pp.rows[1];
    assign pp2 = pp.rows[2];
    assign pp3 = pp.rows[3];

    // rows 1..3 diagonals for columns 2, 3 and 4
    assign red_a = {pp3[1], pp3[0], pp2[0]};
    assign red_b = {pp2[2], pp2[1], pp1[1]};

    ks_adder #(.WIDTH(3)) i_ks_red (
        .in1  (red_a),
        .in2  (red_b),
        .sum  (red_s),
        .cout (red_c)
    );

    assign ha_s = pp1[2] ^ pp0[3];
    assign ha_c = pp1[2] & pp0[3];

    // column 4 still holds three bits, column 5 two
    assign hi_a = {pp3[2], red_s[2]};
    assign hi_b = {pp2[3], pp1[3]};

    ks_adder #(.WIDTH(2)) i_ks_hi (
        .in1  (hi_a),
        .in2  (hi_b),
        .sum  (hi_s),
        .cout (hi_c)
    );

    // at most two bits left per column
    assign add_x = {pp3[3], red_c, ha_c, ha_s, red_s[0], pp1[0]};
    assign add_y = {hi_c, hi_s[1], hi_s[0], red_s[1], pp0[2], pp0[1]};

    ks_adder #(.WIDTH(ADD_W)) i_ks_final (
        .in1  (add_x),
        .in2  (add_y),
        .sum  (add_s),
        .cout (add_c)
    );

    assign product_d = {add_c, add_s, pp0[0]};  // column 0 needs no adding

    // second stage; product holds through bubbles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            product   <= '0;
        end else begin
            out_valid <= pp.valid;
            if (pp.valid) begin
                product <= product_d;
            end
        end
    end

endmodule

`default_nettype wire

// File: ks_adder.sv
`timescale 1ns/1ps
`default_nettype none

module ks_adder #(
    parameter int WIDTH = 6
) (
    input  logic [WIDTH-1:0] in1,
    input  logic [WIDTH-1:0] in2,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    localparam int LEVELS = $clog2(WIDTH);  // prefix levels, span doubles each time

    logic [WIDTH-1:0] gen;    // bitwise generate
    logic [WIDTH-1:0] prop;   // bitwise propagate
    logic [WIDTH-1:0] grp_g;  // group generate over bits i..0
    logic [WIDTH-1:0] carry;  // carry into each bit

    assign gen  = in1 & in2;
    assign prop = in1 ^ in2;

    // Each level combines bit i with bit i-SPAN. Levels before the last
    // use black cells since the group propagate is still needed further up;
    // the last level only needs the generate, so gray cells do.
    for (genvar l = 0; l < LEVELS; l++) begin : g_lvl
        localparam int SPAN = 1 << l;

        logic [WIDTH-1:0] g_in;   // generate from the level below
        logic [WIDTH-1:0] p_in;   // propagate from the level below
        logic [WIDTH-1:0] g_out;  // generate after this level

        if (l == 0) begin : g_src
            assign g_in = gen;
            assign p_in = prop;
        end else begin : g_src
            assign g_in = g_lvl[l-1].g_out;
            assign p_in = g_lvl[l-1].g_bk.p_out;
        end

        // generate half of every cell, gray or black
        for (genvar i = 0; i < WIDTH; i++) begin : g_gc
            if (i < SPAN) begin : g_keep
                assign g_out[i] = g_in[i];  // already complete
            end else begin : g_cell
                assign g_out[i] = g_in[i] | (p_in[i] & g_in[i-SPAN]);
            end
        end

        // propagate half, only on black-cell levels
        if (l < LEVELS - 1) begin : g_bk
            logic [WIDTH-1:0] p_out;  // group propagate after this level

            for (genvar i = 0; i < WIDTH; i++) begin : g_pc
                if (i < SPAN) begin : g_keep
                    assign p_out[i] = p_in[i];
                end else begin : g_cell
                    assign p_out[i] = p_in[i] & p_in[i-SPAN];
                end
            end
        end
    end

    assign grp_g = g_lvl[LEVELS-1].g_out;

    assign carry = {grp_g[WIDTH-2:0], 1'b0};  // carry-in is zero
    assign sum   = prop ^ carry;
    assign cout  = grp_g[WIDTH-1];

endmodule

`default_nettype wire

// File: pp_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "mult_macros.svh"

module pp_gen
    import mult_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  operand_t a,
    input  operand_t b,
    pp_if.gen        pp
);

    logic     valid_q;  // first pipeline strobe
    operand_t a_q;      // selects the rows
    operand_t b_q;      // row contents

    // operands are taken every cycle, valid_q tells bubbles apart
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            a_q     <= '0;
            b_q     <= '0;
        end else begin
            valid_q <= in_valid;
            a_q     <= a;
            b_q     <= b;
        end
    end

    // AND array, one row per bit of a
    for (genvar r = 0; r < `MULT_OP_W; r++) begin : g_row
        assign pp.rows[r] = a_q[r] ? b_q : '0;  // b or zero
    end

    assign pp.valid = valid_q;

endmodule

`default_nettype wire

// File: pp_if.sv
`timescale 1ns/1ps
`default_nettype none

// partial products between the generator stage and the reduction stage
interface pp_if
    import mult_pkg::*;
(
    input logic clk
);

    pp_array_t rows;   // four rows, row i has weight 2**i
    logic      valid;  // qualifies rows in the same cycle

    // generator side drives the rows and strobe
    modport gen (
        input  clk,
        output rows,
        output valid
    );

    // reduction side only reads them
    modport red (
        input  clk,
        input  rows,
        input  valid
    );

endinterface

`default_nettype wire

// File: mult_pkg.sv
`default_nettype none

`include "mult_macros.svh"

package mult_pkg;

    // one unsigned operand
    typedef logic [`MULT_OP_W-1:0] operand_t;

    // one partial-product row, b masked by a single bit of a
    typedef logic [`MULT_OP_W-1:0] pp_row_t;

    // row i carries weight 2**i
    typedef pp_row_t [`MULT_OP_W-1:0] pp_array_t;

    // full unsigned product
    typedef logic [`MULT_PROD_W-1:0] product_t;

endpackage

`default_nettype wire

// File: mult_macros.svh
`ifndef MULT_MACROS_SVH
`define MULT_MACROS_SVH

// operand and product widths of the 4x4 multiplier
`define MULT_OP_W    4  // operand width
`define MULT_PROD_W  8  // product width, twice the operand

// rising edges from in_valid sampled to out_valid high
`define MULT_LATENCY 2

`endif
